// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;      // Register, address and instruction words
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [6:0]                  opcode_t;
  typedef logic [3:0]                  alu_op_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // All four byte lanes, only word accesses are supported
  localparam logic [XLEN/8-1:0] WB_SEL_WORD = 4'b1111;

  // Base opcodes of the RV32I subset
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // ALU operation codes
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // Decoded control bits for one instruction
  typedef struct packed {
    alu_op_t alu_op;
    logic    src_a_pc;   // Operand A is the PC
    logic    src_b_imm;  // Operand B is the immediate
    logic    reg_write;
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    is_load;
    logic    is_store;
    logic    halt;       // ECALL or illegal encoding
  } ctrl_t;

  // Wishbone classic master outputs
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    word_t                adr;
    word_t                dat;
    logic [XLEN/8-1:0]    sel;
  } wb_req_t;

  // Wishbone slave response
  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder
  import rv_pkg::*;
(
  input  word_t i_insn,
  output ctrl_t o_ctrl,
  output word_t o_imm
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  logic       is_reg;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_op_t    alu_sel;
  logic       alu_ok;

  assign opcode  = i_insn[6:0];
  assign funct3  = i_insn[14:12];
  assign funct7  = i_insn[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);  // SUB and SRA
  assign is_reg  = (opcode == OP_REG);

  // Sign-extended immediates of each format
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

  // ALU code shared by register-immediate and register-register forms
  always_comb begin
    alu_sel = ALU_ADD;
    alu_ok  = !is_reg || f7_zero;
    case (funct3)
      3'b000: begin
        alu_sel = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
        alu_ok  = !is_reg || f7_zero || f7_alt;
      end
      3'b001: begin
        alu_sel = ALU_SLL;
        alu_ok  = f7_zero;  // SLLI upper bits must be zero too
      end
      3'b010: alu_sel = ALU_SLT;
      3'b011: alu_sel = ALU_SLTU;
      3'b100: alu_sel = ALU_XOR;
      3'b101: begin
        alu_sel = f7_alt ? ALU_SRA : ALU_SRL;
        alu_ok  = f7_zero || f7_alt;
      end
      3'b110: alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  end

  always_comb begin
    o_ctrl = '0;
    o_imm  = imm_i;
    case (opcode)
      OP_LUI: begin
        o_ctrl.src_b_imm = 1'b1;  // x0 + imm, rs1 index is masked at the top
        o_ctrl.reg_write = 1'b1;
        o_imm            = imm_u;
      end
      OP_AUIPC: begin
        o_ctrl.src_a_pc  = 1'b1;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_imm            = imm_u;
      end
      OP_JAL: begin
        o_ctrl.is_jal    = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_imm            = imm_j;
      end
      OP_JALR: begin
        o_ctrl.is_jalr   = (funct3 == 3'b000);
        o_ctrl.reg_write = (funct3 == 3'b000);
        o_ctrl.halt      = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        // funct3 010 and 011 are not branches
        o_ctrl.is_branch = (funct3[2:1] != 2'b01);
        o_ctrl.halt      = (funct3[2:1] == 2'b01);
        o_imm            = imm_b;
      end
      OP_LOAD: begin
        o_ctrl.is_load   = (funct3 == 3'b010);  // LW only
        o_ctrl.reg_write = (funct3 == 3'b010);
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.halt      = (funct3 != 3'b010);
      end
      OP_STORE: begin
        o_ctrl.is_store  = (funct3 == 3'b010);  // SW only
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.halt      = (funct3 != 3'b010);
        o_imm            = imm_s;
      end
      OP_IMM: begin
        o_ctrl.alu_op    = alu_sel;
        o_ctrl.src_b_imm = 1'b1;
        o_ctrl.reg_write = alu_ok;
        o_ctrl.halt      = !alu_ok;
      end
      OP_REG: begin
        o_ctrl.alu_op    = alu_sel;
        o_ctrl.reg_write = alu_ok;
        o_ctrl.halt      = !alu_ok;
      end
      OP_SYSTEM: o_ctrl.halt = 1'b1;  // ECALL stops, the rest is unsupported
      default:   o_ctrl.halt = 1'b1;
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  input  reg_addr_t i_rd,
  input  logic      i_we,
  input  word_t     i_rd_data,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin  // x0 is never written
      regs[i_rd] <= i_rd_data;
    end
  end

  // Combinational reads with x0 tied to zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Controller keeps write-back quiet during reset
  a_no_write_in_rst: assert property (@(posedge clk) rst |-> !i_we)
    else $error("register write enabled during reset");

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  input  word_t      i_a,
  input  word_t      i_b,
  input  alu_op_t    i_op,
  input  logic [2:0] i_funct3,
  output word_t      o_result,
  output logic       o_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = i_b[4:0];
  assign eq    = (i_a == i_b);
  assign lt_s  = ($signed(i_a) < $signed(i_b));
  assign lt_u  = (i_a < i_b);

  always_comb begin
    case (i_op)
      ALU_ADD:  o_result = i_a + i_b;
      ALU_SUB:  o_result = i_a - i_b;
      ALU_SLL:  o_result = i_a << shamt;
      ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_SRL:  o_result = i_a >> shamt;
      ALU_SRA:  o_result = $signed(i_a) >>> shamt;
      ALU_OR:   o_result = i_a | i_b;
      ALU_AND:  o_result = i_a & i_b;
      default:  o_result = i_a + i_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (i_funct3)
      3'b000:  o_taken = eq;     // BEQ
      3'b001:  o_taken = !eq;    // BNE
      3'b100:  o_taken = lt_s;   // BLT
      3'b101:  o_taken = !lt_s;  // BGE
      3'b110:  o_taken = lt_u;   // BLTU
      3'b111:  o_taken = !lt_u;  // BGEU
      default: o_taken = 1'b0;
    endcase
  end

endmodule

// ==== rv_core_ctrl.sv ====
`timescale 1ns/1ps

module rv_core_ctrl
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  ctrl_t     i_ctrl,
  input  word_t     i_imm,
  input  word_t     i_alu_result,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  input  logic      i_taken,
  input  wb_rsp_t   i_wb,
  output wb_req_t   o_wb,
  output word_t     o_insn,
  output word_t     o_pc,
  output logic      o_rf_we,
  output reg_addr_t o_rf_rd,
  output word_t     o_rf_data,
  output logic      o_halt
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } state_t;

  state_t state;
  state_t state_next;
  word_t  pc;
  word_t  pc_next;
  word_t  pc_plus4;
  word_t  pc_target;
  word_t  jalr_sum;
  word_t  ir;
  logic   ack_q;      // Ack seen last cycle, forces an idle bus cycle
  logic   req;
  logic   bus_done;
  logic   is_mem;
  logic   exec_step;
  logic   store_cyc;

  assign is_mem    = i_ctrl.is_load || i_ctrl.is_store;
  assign exec_step = (state == S_EXEC) && !i_ctrl.halt && !is_mem;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + i_imm;          // Branch and JAL target
  assign jalr_sum  = i_rs1_data + i_imm;

  always_comb begin
    if (i_ctrl.is_jal || (i_ctrl.is_branch && i_taken)) begin
      pc_next = pc_target;
    end else if (i_ctrl.is_jalr) begin
      pc_next = {jalr_sum[XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  // Request only in FETCH and MEM, never right after an ack
  assign req       = ((state == S_FETCH) || (state == S_MEM)) && !ack_q;
  assign bus_done  = req && i_wb.ack;
  assign store_cyc = (state == S_MEM) && i_ctrl.is_store;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:  state_next = S_FETCH;
      S_FETCH: begin
        if (bus_done) begin
          state_next = S_EXEC;
        end
      end
      S_EXEC: begin
        if (i_ctrl.halt) begin
          state_next = S_HALT;
        end else if (is_mem) begin
          state_next = S_MEM;
        end else begin
          state_next = S_FETCH;
        end
      end
      S_MEM: begin
        if (bus_done) begin
          state_next = S_FETCH;
        end
      end
      default: state_next = S_HALT;  // Stays until reset
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
      ack_q <= 1'b0;
    end else begin
      state <= state_next;
      ack_q <= bus_done;
      if (exec_step) begin
        pc <= pc_next;
      end else if ((state == S_MEM) && bus_done) begin
        pc <= pc_plus4;
      end
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if ((state == S_FETCH) && bus_done) begin
      ir <= i_wb.dat;
    end
  end

  // Write-back
  assign o_rf_we = (exec_step && i_ctrl.reg_write) ||
                   ((state == S_MEM) && i_ctrl.is_load && bus_done);
  assign o_rf_rd = ir[11:7];

  always_comb begin
    if (i_ctrl.is_load) begin
      o_rf_data = i_wb.dat;
    end else if (i_ctrl.is_jal || i_ctrl.is_jalr) begin
      o_rf_data = pc_plus4;  // Link address
    end else begin
      o_rf_data = i_alu_result;
    end
  end

  // Wishbone master, data address comes from the ALU
  assign o_wb.cyc = req;
  assign o_wb.stb = req;
  assign o_wb.we  = store_cyc;
  assign o_wb.adr = (state == S_MEM) ? i_alu_result : pc;
  assign o_wb.dat = store_cyc ? i_rs2_data : '0;
  assign o_wb.sel = WB_SEL_WORD;

  assign o_insn = ir;
  assign o_pc   = pc;
  assign o_halt = (state == S_HALT);

  // Bus idles for one cycle after every ack
  a_idle_after_ack: assert property (@(posedge clk) disable iff (rst)
    (o_wb.stb && i_wb.ack) |=> (!o_wb.cyc && !o_wb.stb))
    else $error("bus request held after ack");

  // Whole request held until the slave acks
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (o_wb.stb && !i_wb.ack) |=> $stable(o_wb))
    else $error("bus request changed before ack");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("PC not word-aligned");

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_rsp_t i_wb,
  output wb_req_t o_wb,
  output logic    o_halt
);

  word_t     insn;
  word_t     imm;
  word_t     pc;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  word_t     rf_data;
  ctrl_t     ctrl;
  reg_addr_t rs1_idx;
  reg_addr_t rs2_idx;
  reg_addr_t rf_rd;
  logic      rf_we;
  logic      taken;

  // LUI reads x0 so the ALU passes the immediate through
  assign rs1_idx = (insn[6:0] == OP_LUI) ? '0 : insn[19:15];
  assign rs2_idx = insn[24:20];

  // Operand selectors
  assign alu_a = ctrl.src_a_pc  ? pc  : rs1_data;
  assign alu_b = ctrl.src_b_imm ? imm : rs2_data;

  rv_decoder u_decoder (
    .i_insn (insn),
    .o_ctrl (ctrl),
    .o_imm  (imm)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1_idx),
    .i_rs2      (rs2_idx),
    .i_rd       (rf_rd),
    .i_we       (rf_we),
    .i_rd_data  (rf_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (ctrl.alu_op),
    .i_funct3 (insn[14:12]),
    .o_result (alu_result),
    .o_taken  (taken)
  );

  rv_core_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_ctrl       (ctrl),
    .i_imm        (imm),
    .i_alu_result (alu_result),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_taken      (taken),
    .i_wb         (i_wb),
    .o_wb         (o_wb),
    .o_insn       (insn),
    .o_pc         (pc),
    .o_rf_we      (rf_we),
    .o_rf_rd      (rf_rd),
    .o_rf_data    (rf_data),
    .o_halt       (o_halt)
  );

endmodule

// ==== tb_rv_programs.svh ====
`ifndef TB_RV_PROGRAMS_SVH
`define TB_RV_PROGRAMS_SVH

// Test programs, padded with zero words which decode as illegal
localparam int NUM_PROGS = 8;

localparam string PROG_NAME [NUM_PROGS] = '{
  "alu_reg", "alu_logic", "alu_imm", "branch_a",
  "branch_b", "jumps", "mem_auipc", "illegal_halt"
};

localparam word_t PROG_INSN [NUM_PROGS][PROG_LEN] = '{
  // add, sub, slt, sltu, sra, srl on -7 and 3, then a store behind ECALL
  '{'hFF900093, 'h00300113, 'h002081B3, 'h10302023, 'h40208233, 'h10402223,
    'h0020A2B3, 'h10502423, 'h0020B333, 'h10602623, 'h4020D3B3, 'h10702823,
    'h0020D433, 'h10802A23, 'h00000073, 'h10102C23},
  // xor, or, and, sll, write to x0, ori
  '{'h123450B7, 'h67808093, 'h0F000113, 'h0020C1B3, 'h10302023, 'h0020E233,
    'h10402223, 'h0020F2B3, 'h10502423, 'h00209333, 'h10602623, 'h00500013,
    'h10002823, 'hF0016393, 'h10702A23, 'h00000073},
  // slti, sltiu, xori, andi, slli, srli, srai on -16
  '{'hFF000093, 'hFF10A113, 'h10202023, 'hFFF0B193, 'h10302223, 'h0FF0C213,
    'h10402423, 'h7F00F313, 'h10602623, 'h00409393, 'h0083D413, 'h10802823,
    'h4083D493, 'h10902A23, 'h00000073, 'h0},
  // beq, bne, blt, each taken then not taken, marker bit set when not taken
  '{'hFFF00093, 'h00100113, 'h00108463, 'h00156513, 'h00208463, 'h00256513,
    'h00209463, 'h00456513, 'h00211463, 'h00856513, 'h0020C463, 'h01056513,
    'h00114463, 'h02056513, 'h10A02023, 'h00000073},
  // bge, bltu, bgeu, each not taken then taken
  '{'hFFF00093, 'h00100113, 'h0020D463, 'h00156513, 'h00115463, 'h00256513,
    'h0020E463, 'h00456513, 'h00116463, 'h00856513, 'h00117463, 'h01056513,
    'h0020F463, 'h02056513, 'h10A02023, 'h00000073},
  // jal over an ECALL, jalr to 26+3 lands on 28
  '{'h008000EF, 'h00000073, 'h10102023, 'h01A00293, 'h00328167, 'h00000073,
    'h00000073, 'h10202223, 'h00000073, 'h0, 'h0, 'h0,
    'h0, 'h0, 'h0, 'h0},
  // sw and lw through a base register, auipc at 24
  '{'hDEADC0B7, 'hEEF08093, 'h1F000293, 'h0012A823, 'h0102A183, 'h10302023,
    'h12345217, 'h10402223, 'h00000073, 'h0, 'h0, 'h0,
    'h0, 'h0, 'h0, 'h0},
  // fence is unsupported, the store after it must not happen
  '{'h05500093, 'h10102023, 'h0000000F, 'h10102223, 'h00000073, 'h0,
    'h0, 'h0, 'h0, 'h0, 'h0, 'h0,
    'h0, 'h0, 'h0, 'h0}
};

localparam int EXP_COUNT [NUM_PROGS] = '{6, 6, 6, 1, 1, 2, 3, 1};

localparam word_t EXP_ADR [NUM_PROGS][MAX_STORES] = '{
  '{'h100, 'h104, 'h108, 'h10C, 'h110, 'h114, 'h0, 'h0},
  '{'h100, 'h104, 'h108, 'h10C, 'h110, 'h114, 'h0, 'h0},
  '{'h100, 'h104, 'h108, 'h10C, 'h110, 'h114, 'h0, 'h0},
  '{'h100, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'h100, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'h100, 'h104, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'h200, 'h100, 'h104, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'h100, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0}
};

localparam word_t EXP_DAT [NUM_PROGS][MAX_STORES] = '{
  '{'hFFFFFFFC, 'hFFFFFFF6, 'h00000001, 'h00000000,
    'hFFFFFFFF, 'h1FFFFFFF, 'h0, 'h0},
  '{'h12345688, 'h123456F8, 'h00000070, 'h56780000,
    'h00000000, 'hFFFFFFF0, 'h0, 'h0},
  '{'h00000001, 'h00000001, 'hFFFFFF0F, 'h000007F0,
    'h00FFFFFF, 'hFFFFFFFF, 'h0, 'h0},
  '{'h0000002A, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},  // Not-taken bits 1, 3, 5
  '{'h00000015, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},  // Not-taken bits 0, 2, 4
  '{'h00000004, 'h00000014, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'hDEADBEEF, 'hDEADBEEF, 'h12345018, 'h0, 'h0, 'h0, 'h0, 'h0},
  '{'h00000055, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0}
};

`endif

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam int MEM_WORDS    = 256;
  localparam int ADR_MSB      = $clog2(MEM_WORDS) + 1;
  localparam int PROG_LEN     = 16;
  localparam int MAX_STORES   = 8;
  localparam int HALT_TIMEOUT = 2000;   // Cycles allowed per program
  localparam int QUIET_CYCLES = 10;

  `include "tb_rv_programs.svh"

  logic    clk;
  logic    rst;
  logic    halt;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp = '0;
  wb_req_t held_req;          // Request as first seen by the memory
  logic    pending;
  int      wait_cnt;
  int      max_wait;
  int      seed;
  string   cur_name;
  word_t   mem [MEM_WORDS];
  word_t   store_adr [$];
  word_t   store_dat [$];

  rv_core dut (
    .clk    (clk),
    .rst    (rst),
    .i_wb   (wb_rsp),
    .o_wb   (wb_req),
    .o_halt (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_sim();
    $display("RESULT: FAIL");
    $fatal(1, "Testbench stopped at first failure");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error: %s, %s: expected %h, actual %h", cur_name, what, exp, act);
      stop_sim();
    end
  endtask

  task automatic check_halt(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s, %s: expected %b, actual %b", cur_name, what, exp, act);
      stop_sim();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("** Error: %s, %s: expected %0d, actual %0d", cur_name, what, exp, act);
      stop_sim();
    end
  endtask

  // Wishbone slave memory, one ack pulse after a drawn number of wait states
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_rsp  <= '0;
      pending <= 1'b0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;
      pending    <= 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!pending) begin
        pending  <= 1'b1;
        held_req <= wb_req;
        wait_cnt <= (max_wait == 0) ? 0 : $unsigned($random(seed)) % (max_wait + 1);
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        if (wb_req.adr >= MEM_WORDS * 4) begin
          $display("%s: bus access outside the memory at %h", cur_name, wb_req.adr);
          stop_sim();
        end
        check_word("request address held", held_req.adr, wb_req.adr);
        check_word("address alignment", 32'h0000_0000, word_t'(wb_req.adr[1:0]));
        check_word("byte select", 32'h0000_000F, word_t'(wb_req.sel));
        if (wb_req.we) begin
          check_word("store data held", held_req.dat, wb_req.dat);
          mem[wb_req.adr[ADR_MSB:2]] = wb_req.dat;
          store_adr.push_back(wb_req.adr);
          store_dat.push_back(wb_req.dat);
        end
        wb_rsp.dat <= mem[wb_req.adr[ADR_MSB:2]];
        wb_rsp.ack <= 1'b1;
      end
    end
  end

  task automatic run_program(input int p);
    int cycles;
    cur_name = PROG_NAME[p];
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    // Unused words hold illegal opcodes that vary with the address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i < PROG_LEN) ? PROG_INSN[p][i] : {~i[24:0], 7'b0000000};
    end
    store_adr.delete();
    store_dat.delete();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_halt("halt low out of reset", 1'b0, halt);
    cycles = 0;
    while (halt !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > HALT_TIMEOUT) begin
        $display("Timeout: %s did not raise o_halt in %0d cycles", cur_name, HALT_TIMEOUT);
        stop_sim();
      end
    end
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_halt("halt held", 1'b1, halt);
      if (wb_req.cyc) begin
        $display("%s: bus cycle started after halt", cur_name);
        stop_sim();
      end
    end
    check_count("store count", EXP_COUNT[p], store_adr.size());
    for (int i = 0; i < store_adr.size(); i++) begin
      check_word($sformatf("store %0d address", i), EXP_ADR[p][i], store_adr[i]);
      check_word($sformatf("store %0d data", i), EXP_DAT[p][i], store_dat[i]);
    end
  endtask

  initial begin
    rst      = 1'b1;
    seed     = 32'h3f625690;
    max_wait = 0;
    // Second round repeats every program under random back-pressure
    for (int round = 0; round < 2; round++) begin
      max_wait = round * 3;
      for (int p = 0; p < NUM_PROGS; p++) begin
        run_program(p);
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_core_ctrl.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_core_ctrl.sv
  - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
